// File: decode.f
verilog/rv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
verilog/address_unit.sv
verilog/decode_stage.sv
verilog/decode_top.sv
verification/decode_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module decode_tb -Mdir obj_dir -f decode.f

./obj_dir/Vdecode_tb > sim.log
cat sim.log

# A missing pass line makes grep, and so this script, exit with failure.
grep -qx "TEST OK" sim.log

// File: verification/decode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decode_tb;

  logic clk;
  logic rst;
  decode_pkg::fetch_item_t fetch;
  logic hold;
  logic clear;
  decode_pkg::wb_write_t ex_fwd;
  decode_pkg::wb_write_t wb;
  decode_pkg::decode_item_t item;
  decode_pkg::dmem_req_t dmem;
  logic jump;

  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  bit aborted;
  logic [31:0] lfsr_state;
  logic [31:0] pc_next;
  decode_pkg::dmem_req_t dmem_cap; // Request seen in the cycle the word was decoded.
  decode_pkg::decode_item_t exp_i;
  decode_pkg::decode_item_t mask_i;

  decode_top dut_i (
    .clk(clk),
    .rst(rst),
    .fetch(fetch),
    .hold(hold),
    .clear(clear),
    .ex_fwd(ex_fwd),
    .wb(wb),
    .item(item),
    .dmem(dmem),
    .jump(jump)
  );

  always #10 clk = ~clk;

  // Taps 32, 22, 2 and 1 with one shift for each bit taken.
  function automatic logic [31:0] lfsr_word();
    logic fb;
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic logic [31:0] take_pc();
    logic [31:0] pc;
    pc = pc_next;
    pc_next = pc_next + 32'd16; // Every word gets a pc of its own.
    return pc;
  endfunction

  function automatic logic [31:0] i_type(input int imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input rv_isa_pkg::opcode_e op);
    logic [31:0] v;
    v = imm;
    return {v[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    logic [31:0] v;
    v = imm;
    return {v[11:5], rs2, rs1, f3, v[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    logic [31:0] v;
    v = imm;
    return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input rv_isa_pkg::opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input logic [4:0] rd);
    logic [31:0] v;
    v = imm;
    return {v[20], v[10:1], v[11], v[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  task automatic compare_item(input string name, input decode_pkg::decode_item_t exp,
      input decode_pkg::decode_item_t act, input decode_pkg::decode_item_t mask);
    if (((exp ^ act) & mask) !== '0) begin
      $display("ERR %s expected %h actual %h", name, exp & mask, act & mask);
      errors++;
      test_errors++;
    end
  endtask

  task automatic compare_dmem(input string name, input decode_pkg::dmem_req_t exp,
      input decode_pkg::dmem_req_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic apply_reset();
    rst = 1'b0;
    fetch = '0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b1;
  endtask

  // The register file writes on the edge, so one cycle of wb is enough.
  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb = {1'b1, addr, data};
    @(posedge clk);
    #2;
    wb = '0;
  endtask

  // Called 2 ns after an edge, and returns 2 ns after the edge that registered the item.
  task automatic present(input string name, input logic [31:0] pc, input logic [31:0] instr,
      input logic hold_v, input logic clear_v, input logic [31:0] exp_pc);
    int n;
    if (aborted) return;
    fetch = {pc, instr, 1'b1};
    hold = hold_v;
    clear = clear_v;
    #9;
    dmem_cap = dmem;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (item.pc !== exp_pc && n < 4);
    #1;
    fetch = '0;
    hold = 1'b0;
    clear = 1'b0;
    if (item.pc !== exp_pc) begin
      $display("%s: no item with pc %h appeared within %0d cycles", name, exp_pc, n);
      errors++;
      test_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic clear_expect();
    exp_i = '0;
    mask_i = '0;
  endtask

  task automatic mask_enables();
    {mask_i.wren, mask_i.rden1, mask_i.rden2, mask_i.auipc, mask_i.lui} = '1;
    {mask_i.jal, mask_i.jalr, mask_i.branch, mask_i.load, mask_i.store} = '1;
    {mask_i.ecall, mask_i.ebreak, mask_i.valid, mask_i.jump, mask_i.exception} = '1;
  endtask

  task automatic check_alu(input string name, input logic [31:0] instr,
      input logic [31:0] imm, input logic [4:0] rd, input rv_isa_pkg::alu_op_e op,
      input logic [31:0] r1, input logic [31:0] r2);
    logic [31:0] pc;
    pc = take_pc();
    present(name, pc, instr, 1'b0, 1'b0, pc);
    clear_expect();
    {exp_i.pc, exp_i.npc, exp_i.imm, exp_i.waddr} = {pc, pc + 32'd4, imm, rd};
    {exp_i.rdata1, exp_i.rdata2} = {r1, r2};
    exp_i.alu_op = op;
    {exp_i.wren, exp_i.valid, exp_i.exception} = 3'b110;
    {mask_i.pc, mask_i.npc, mask_i.imm, mask_i.waddr, mask_i.rdata1, mask_i.rdata2} = '1;
    mask_i.alu_op = rv_isa_pkg::alu_op_e'(4'hf);
    {mask_i.wren, mask_i.valid, mask_i.exception} = 3'b111;
    compare_item(name, exp_i, item, mask_i);
  endtask

  task automatic alu_decode();
    logic [31:0] a;
    logic [31:0] b;
    a = lfsr_word();
    b = lfsr_word();
    write_reg(5'd5, a);
    write_reg(5'd6, b);
    check_alu("addi", i_type(-291, 5'd5, 3'b000, 5'd7, rv_isa_pkg::op_imm), 32'(-291),
              5'd7, rv_isa_pkg::alu_add, a, 32'd0);
    check_alu("lui", u_type(20'habcde, 5'd8, rv_isa_pkg::op_lui), 32'habcde000,
              5'd8, rv_isa_pkg::alu_add, 32'd0, 32'd0);
    check_alu("auipc", u_type(20'h12345, 5'd9, rv_isa_pkg::op_auipc), 32'h12345000,
              5'd9, rv_isa_pkg::alu_add, 32'd0, 32'd0);
    check_alu("add", r_type(7'b0000000, 5'd6, 5'd5, 3'b000, 5'd10), 32'd0,
              5'd10, rv_isa_pkg::alu_add, a, b);
    check_alu("sub", r_type(7'b0100000, 5'd6, 5'd5, 3'b000, 5'd11), 32'd0,
              5'd11, rv_isa_pkg::alu_sub, a, b);
    report_test("alu_decode");
  endtask

  task automatic check_operands(input string name, input logic [31:0] instr,
      input logic [31:0] r1, input logic [31:0] r2);
    logic [31:0] pc;
    pc = take_pc();
    present(name, pc, instr, 1'b0, 1'b0, pc);
    clear_expect();
    {exp_i.rdata1, exp_i.rdata2} = {r1, r2};
    {exp_i.raddr1, exp_i.raddr2} = {instr[19:15], instr[24:20]};
    {mask_i.rdata1, mask_i.rdata2} = '1;
    {mask_i.raddr1, mask_i.raddr2} = '1;
    compare_item(name, exp_i, item, mask_i);
  endtask

  task automatic forwarding();
    logic [31:0] e;
    logic [31:0] w;
    logic [31:0] instr;
    e = lfsr_word();
    w = lfsr_word();
    write_reg(5'd20, lfsr_word());
    instr = r_type(7'b0000000, 5'd20, 5'd20, 3'b000, 5'd21);
    ex_fwd = {1'b1, 5'd20, e};
    wb = {1'b1, 5'd20, w};
    check_operands("fwd execute", instr, e, e);
    w = lfsr_word();
    ex_fwd.wren = 1'b0;
    wb.wdata = w;
    check_operands("fwd writeback", instr, w, w);
    wb.wren = 1'b0;
    wb.wdata = lfsr_word(); // A disabled port carries data that must not be picked.
    check_operands("fwd file", instr, w, w); // The last writeback landed in the file.
    ex_fwd = {1'b1, 5'd0, e};
    wb = {1'b1, 5'd0, w};
    check_operands("fwd x0", r_type(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd21), 32'd0, 32'd0);
    ex_fwd = '0;
    wb = '0;
    report_test("forwarding");
  endtask

  task automatic check_target(input string name, input logic [31:0] target,
      input logic taken);
    clear_expect();
    {exp_i.address, exp_i.jump} = {target, taken};
    {mask_i.address, mask_i.jump} = '1;
    compare_item(name, exp_i, item, mask_i);
    compare_bit({name, " jump"}, taken, jump);
  endtask

  task automatic check_branch(input logic [2:0] f3, input logic [4:0] rs2,
      input logic [31:0] r1, input logic [31:0] r2);
    logic [31:0] pc;
    logic taken;
    string name;
    name = $sformatf("branch f3=%0d x%0d", f3, rs2);
    pc = take_pc();
    present(name, pc, b_type(-64, rs2, 5'd12, f3), 1'b0, 1'b0, pc);
    case (f3)
      3'b000: taken = (r1 == r2);
      3'b001: taken = (r1 != r2);
      3'b100: taken = ($signed(r1) < $signed(r2));
      3'b101: taken = ($signed(r1) >= $signed(r2));
      3'b110: taken = (r1 < r2);
      default: taken = (r1 >= r2);
    endcase
    check_target(name, pc - 32'd64, taken);
  endtask

  task automatic jumps_and_branches();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] target;
    int off;
    a = lfsr_word();
    b = lfsr_word();
    write_reg(5'd12, a);
    write_reg(5'd13, b);
    write_reg(5'd14, a);
    pc = take_pc();
    present("jal", pc, j_type(2048, 5'd1), 1'b0, 1'b0, pc);
    check_target("jal", pc + 32'd2048, 1'b1);
    pc = take_pc();
    off = a[0] ? -2 : -3; // The sum is odd so bit 0 has to be cleared.
    present("jalr", pc, i_type(off, 5'd12, 3'b000, 5'd1, rv_isa_pkg::op_jalr), 1'b0, 1'b0, pc);
    target = a + 32'(off);
    target[0] = 1'b0;
    check_target("jalr", target, 1'b1);
    check_branch(3'b000, 5'd13, a, b);
    check_branch(3'b000, 5'd14, a, a); // Equal operands so beq is taken at least once.
    check_branch(3'b001, 5'd13, a, b);
    check_branch(3'b100, 5'd13, a, b);
    check_branch(3'b101, 5'd13, a, b);
    check_branch(3'b110, 5'd13, a, b);
    check_branch(3'b111, 5'd13, a, b);
    report_test("jumps_and_branches");
  endtask

  task automatic check_access(input string name, input logic [31:0] instr,
      input logic [31:0] addr, input logic [3:0] be, input logic [31:0] wdata,
      input logic [3:0] wstrb);
    logic [31:0] pc;
    pc = take_pc();
    present(name, pc, instr, 1'b0, 1'b0, pc);
    compare_dmem(name, {1'b1, addr, wdata, wstrb}, dmem_cap);
    clear_expect();
    {exp_i.address, exp_i.byteenable, exp_i.exception} = {addr, be, 1'b0};
    {mask_i.address, mask_i.byteenable, mask_i.exception} = '1;
    compare_item(name, exp_i, item, mask_i);
  endtask

  task automatic loads_and_stores();
    logic [31:0] base;
    logic [31:0] d;
    base = lfsr_word() & 32'hfffffff0;
    d = lfsr_word();
    write_reg(5'd15, base);
    write_reg(5'd16, d);
    // Loads read no rs2, so the write data is zero as well.
    check_access("lb", i_type(1, 5'd15, 3'b000, 5'd17, rv_isa_pkg::op_load),
                 base + 32'd1, 4'b0010, 32'd0, 4'b0000);
    check_access("lh", i_type(2, 5'd15, 3'b001, 5'd17, rv_isa_pkg::op_load),
                 base + 32'd2, 4'b1100, 32'd0, 4'b0000);
    check_access("lw", i_type(4, 5'd15, 3'b010, 5'd17, rv_isa_pkg::op_load),
                 base + 32'd4, 4'b1111, 32'd0, 4'b0000);
    check_access("sb", s_type(3, 5'd16, 5'd15, 3'b000), base + 32'd3, 4'b1000,
                 {4{d[7:0]}}, 4'b1000);
    check_access("sh", s_type(6, 5'd16, 5'd15, 3'b001), base + 32'd6, 4'b1100,
                 {2{d[15:0]}}, 4'b1100);
    check_access("sw", s_type(-4, 5'd16, 5'd15, 3'b010), base - 32'd4, 4'b1111, d, 4'b1111);
    report_test("loads_and_stores");
  endtask

  task automatic check_trap(input string name, input logic [31:0] instr,
      input logic [31:0] step, input rv_isa_pkg::ecause_e cause, input logic [31:0] tval);
    logic [31:0] pc;
    pc = take_pc();
    present(name, pc, instr, 1'b0, 1'b0, pc);
    clear_expect();
    {exp_i.pc, exp_i.npc, exp_i.exception, exp_i.etval} = {pc, pc + step, 1'b1, tval};
    exp_i.ecause = cause;
    {mask_i.pc, mask_i.npc, mask_i.exception, mask_i.etval} = '1;
    mask_i.ecause = rv_isa_pkg::ecause_e'(4'hf);
    compare_item(name, exp_i, item, mask_i);
    compare_bit({name, " mem_valid"}, 1'b0, dmem_cap.mem_valid);
  endtask

  task automatic exceptions();
    logic [31:0] base;
    base = lfsr_word() & 32'hfffffff0;
    write_reg(5'd15, base);
    check_trap("illegal", 32'hffffffff, 32'd4, rv_isa_pkg::ecause_illegal, 32'hffffffff);
    check_trap("compressed", 32'h00004501, 32'd2, rv_isa_pkg::ecause_illegal, 32'h00004501);
    check_trap("ecall", 32'h00000073, 32'd4, rv_isa_pkg::ecause_ecall_m, 32'h00000073);
    check_trap("ebreak", 32'h00100073, 32'd4, rv_isa_pkg::ecause_breakpoint, 32'h00100073);
    check_trap("lh misaligned", i_type(1, 5'd15, 3'b001, 5'd17, rv_isa_pkg::op_load),
               32'd4, rv_isa_pkg::ecause_load_misaligned, base + 32'd1);
    check_trap("sw misaligned", s_type(2, 5'd16, 5'd15, 3'b010),
               32'd4, rv_isa_pkg::ecause_store_misaligned, base + 32'd2);
    report_test("exceptions");
  endtask

  task automatic hold_and_clear();
    logic [31:0] pc;
    logic [31:0] pc_jal;
    write_reg(5'd15, lfsr_word() & 32'hfffffff0);
    pc = take_pc();
    present("store before hold", pc, s_type(8, 5'd16, 5'd15, 3'b010), 1'b0, 1'b0, pc);
    compare_bit("store before hold mem_valid", 1'b1, dmem_cap.mem_valid);
    compare_bit("store before hold store", 1'b1, item.store);
    // The new fetch word is ignored and the held store comes back as a bubble.
    present("hold", take_pc(), r_type(7'b0, 5'd6, 5'd5, 3'b000, 5'd10), 1'b1, 1'b0, pc);
    compare_bit("hold mem_valid", 1'b0, dmem_cap.mem_valid);
    clear_expect();
    mask_enables();
    {exp_i.pc, exp_i.imm} = {pc, 32'd8};
    {mask_i.pc, mask_i.imm} = '1;
    compare_item("hold", exp_i, item, mask_i);
    pc_jal = take_pc();
    present("clear", pc_jal, j_type(64, 5'd1), 1'b0, 1'b1, pc_jal);
    clear_expect();
    mask_enables();
    compare_item("clear", exp_i, item, mask_i);
    compare_bit("clear jump", 1'b0, jump);
    if (!aborted) begin
      apply_reset();
      clear_expect();
      mask_enables();
      compare_item("reset", exp_i, item, mask_i);
      compare_bit("reset mem_valid", 1'b0, dmem.mem_valid);
      compare_bit("reset jump", 1'b0, jump);
    end
    report_test("hold_and_clear");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    fetch = '0;
    hold = 1'b0;
    clear = 1'b0;
    ex_fwd = '0;
    wb = '0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    lfsr_state = 32'h13f87a1e;
    pc_next = 32'h00001000;
    apply_reset();
    if (!aborted) alu_decode();
    if (!aborted) forwarding();
    if (!aborted) jumps_and_branches();
    if (!aborted) loads_and_stores();
    if (!aborted) exceptions();
    if (!aborted) hold_and_clear();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module decode_top (
  input logic clk,
  input logic rst,
  input decode_pkg::fetch_item_t fetch,
  input logic hold,
  input logic clear,
  input decode_pkg::wb_write_t ex_fwd,
  input decode_pkg::wb_write_t wb,
  output decode_pkg::decode_item_t item,
  output decode_pkg::dmem_req_t dmem,
  output logic jump
);

  logic [31:0] dec_instr;
  decode_pkg::decoder_ctrl_t ctrl;
  logic [4:0] raddr1;
  logic [4:0] raddr2;
  logic rden1;
  logic rden2;
  logic [31:0] file1;
  logic [31:0] file2;
  logic [31:0] data1;
  logic [31:0] data2;
  rv_isa_pkg::bcu_op_e bcu_op;
  logic taken;
  decode_pkg::agu_req_t agu_req;
  decode_pkg::agu_res_t agu_res;

  assign jump = item.jump; // Fetch redirects on this level.

  decode_stage stage (
    .clk(clk),
    .rst(rst),
    .fetch(fetch),
    .hold(hold),
    .clear(clear),
    .ctrl(ctrl),
    .dec_instr(dec_instr),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rden1(rden1),
    .rden2(rden2),
    .data1(data1),
    .data2(data2),
    .bcu_op(bcu_op),
    .taken(taken),
    .agu_req(agu_req),
    .agu_res(agu_res),
    .dmem(dmem),
    .item(item)
  );

  instr_decoder decoder (
    .instr(dec_instr),
    .ctrl(ctrl)
  );

  register_file regs (
    .clk(clk),
    .rst(rst),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(file1),
    .rdata2(file2),
    .wr(wb)
  );

  operand_forward forward (
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rden1(rden1),
    .rden2(rden2),
    .file1(file1),
    .file2(file2),
    .ex_fwd(ex_fwd),
    .wb(wb),
    .data1(data1),
    .data2(data2)
  );

  branch_unit bcu (
    .rdata1(data1),
    .rdata2(data2),
    .bcu_op(bcu_op),
    .taken(taken)
  );

  address_unit agu (
    .req(agu_req),
    .res(agu_res)
  );

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input logic clk,
  input logic rst,
  input decode_pkg::fetch_item_t fetch,
  input logic hold,
  input logic clear,
  input decode_pkg::decoder_ctrl_t ctrl,
  output logic [31:0] dec_instr,
  output logic [4:0] raddr1,
  output logic [4:0] raddr2,
  output logic rden1,
  output logic rden2,
  input logic [31:0] data1,
  input logic [31:0] data2,
  output rv_isa_pkg::bcu_op_e bcu_op,
  input logic taken,
  output decode_pkg::agu_req_t agu_req,
  input decode_pkg::agu_res_t agu_res,
  output decode_pkg::dmem_req_t dmem,
  output decode_pkg::decode_item_t item
);

  decode_pkg::decode_item_t item_q;
  decode_pkg::decode_item_t v;
  logic [31:0] instr_q; // Holds the instruction behind item_q for re-decoding during hold.
  logic bubble;

  assign bubble = hold || clear || !fetch.valid;

  always_comb begin
    v = '0;
    // A held stage keeps working on the instruction it already owns.
    v.pc = hold ? item_q.pc : fetch.pc;
    dec_instr = hold ? instr_q : fetch.instr;

    v.waddr = dec_instr[11:7];
    v.raddr1 = dec_instr[19:15];
    v.raddr2 = dec_instr[24:20];
    v.imm = ctrl.imm;
    v.wren = ctrl.wren;
    v.rden1 = ctrl.rden1;
    v.rden2 = ctrl.rden2;
    v.auipc = ctrl.auipc;
    v.lui = ctrl.lui;
    v.jal = ctrl.jal;
    v.jalr = ctrl.jalr;
    v.branch = ctrl.branch;
    v.load = ctrl.load;
    v.store = ctrl.store;
    v.ecall = ctrl.ecall;
    v.ebreak = ctrl.ebreak;
    v.valid = ctrl.valid;
    v.alu_op = ctrl.alu_op;
    v.bcu_op = ctrl.bcu_op;
    v.lsu_op = ctrl.lsu_op;
    v.npc = v.pc + ((dec_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);

    raddr1 = v.raddr1;
    raddr2 = v.raddr2;
    rden1 = v.rden1;
    rden2 = v.rden2;
    v.rdata1 = data1;
    v.rdata2 = data2;

    bcu_op = v.bcu_op;
    v.jump = v.jal || v.jalr || (v.branch && taken);

    agu_req.rdata1 = v.rdata1;
    agu_req.imm = v.imm;
    agu_req.pc = v.pc;
    agu_req.jalr = v.jalr;
    agu_req.load = v.load;
    agu_req.store = v.store;
    agu_req.lsu_op = v.lsu_op;
    v.address = agu_res.address;
    v.byteenable = agu_res.byteenable;
    v.exception = agu_res.exception;
    v.ecause = agu_res.ecause;
    v.etval = agu_res.address;

    // Decoder-side causes override a misaligned address.
    if (!v.valid || v.ebreak || v.ecall) begin
      v.exception = 1'b1;
      v.etval = dec_instr;
      v.ecause = v.ecall ? rv_isa_pkg::ecause_ecall_m :
                 v.ebreak ? rv_isa_pkg::ecause_breakpoint : rv_isa_pkg::ecause_illegal;
    end

    if (bubble) begin
      v.wren = 1'b0;
      v.rden1 = 1'b0;
      v.rden2 = 1'b0;
      v.auipc = 1'b0;
      v.lui = 1'b0;
      v.jal = 1'b0;
      v.jalr = 1'b0;
      v.branch = 1'b0;
      v.load = 1'b0;
      v.store = 1'b0;
      v.ecall = 1'b0;
      v.ebreak = 1'b0;
      v.valid = 1'b0;
      v.jump = 1'b0;
      v.exception = 1'b0;
    end

    dmem.mem_valid = (v.load || v.store) && !v.exception;
    dmem.mem_addr = v.address;
    case (v.lsu_op)
      rv_isa_pkg::lsu_sb: dmem.mem_wdata = {4{v.rdata2[7:0]}};
      rv_isa_pkg::lsu_sh: dmem.mem_wdata = {2{v.rdata2[15:0]}};
      default: dmem.mem_wdata = v.rdata2;
    endcase
    dmem.mem_wstrb = v.store ? v.byteenable : 4'b0000;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      item_q <= '0;
    end else begin
      item_q <= v;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      instr_q <= fetch.instr;
    end
  end

  assign item = item_q;

  // An issued memory request must come back as the next registered load or store.
  assert property (@(posedge clk) disable iff (!rst)
    dmem.mem_valid |-> (!hold && !clear) ##1 (item_q.load || item_q.store));

endmodule

`default_nettype wire

// File: verilog/address_unit.sv
`timescale 1ns/10ps
`default_nettype none

module address_unit (
  input decode_pkg::agu_req_t req,
  output decode_pkg::agu_res_t res
);

  logic [31:0] base;
  logic [31:0] sum;
  logic misaligned;

  // Register-relative for jalr and memory, pc-relative for jal and branches.
  assign base = (req.jalr || req.load || req.store) ? req.rdata1 : req.pc;
  assign sum = base + req.imm;

  always_comb begin
    res.address = req.jalr ? {sum[31:1], 1'b0} : sum;
    case (req.lsu_op)
      rv_isa_pkg::lsu_lb, rv_isa_pkg::lsu_lbu, rv_isa_pkg::lsu_sb: begin
        res.byteenable = 4'b0001 << sum[1:0];
        misaligned = 1'b0;
      end
      rv_isa_pkg::lsu_lh, rv_isa_pkg::lsu_lhu, rv_isa_pkg::lsu_sh: begin
        res.byteenable = 4'b0011 << sum[1:0];
        misaligned = sum[0];
      end
      default: begin
        res.byteenable = 4'b1111;
        misaligned = (sum[1:0] != 2'b00);
      end
    endcase
    res.exception = misaligned && (req.load || req.store);
    res.ecause = req.store ? rv_isa_pkg::ecause_store_misaligned
                           : rv_isa_pkg::ecause_load_misaligned;
  end

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input logic [31:0] rdata1,
  input logic [31:0] rdata2,
  input rv_isa_pkg::bcu_op_e bcu_op,
  output logic taken
);

  logic equal;
  logic less_signed;
  logic less_unsigned;

  assign equal = (rdata1 == rdata2);
  assign less_signed = ($signed(rdata1) < $signed(rdata2));
  assign less_unsigned = (rdata1 < rdata2);

  always_comb begin
    case (bcu_op)
      rv_isa_pkg::bcu_beq: taken = equal;
      rv_isa_pkg::bcu_bne: taken = !equal;
      rv_isa_pkg::bcu_blt: taken = less_signed;
      rv_isa_pkg::bcu_bge: taken = !less_signed;
      rv_isa_pkg::bcu_bltu: taken = less_unsigned;
      rv_isa_pkg::bcu_bgeu: taken = !less_unsigned;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
  input logic [4:0] raddr1,
  input logic [4:0] raddr2,
  input logic rden1,
  input logic rden2,
  input logic [31:0] file1,
  input logic [31:0] file2,
  input decode_pkg::wb_write_t ex_fwd,
  input decode_pkg::wb_write_t wb,
  output logic [31:0] data1,
  output logic [31:0] data2
);

  // The execute result is younger than writeback, so it wins a tie.
  function automatic logic [31:0] select_operand(
    input logic [4:0] addr,
    input logic rden,
    input logic [31:0] file_data
  );
    logic [31:0] data;
    if (!rden || addr == 5'd0) begin
      data = 32'd0;
    end else if (ex_fwd.wren && ex_fwd.waddr == addr) begin
      data = ex_fwd.wdata;
    end else if (wb.wren && wb.waddr == addr) begin
      data = wb.wdata;
    end else begin
      data = file_data;
    end
    return data;
  endfunction

  always_comb begin
    data1 = select_operand(raddr1, rden1, file1);
    data2 = select_operand(raddr2, rden2, file2);
  end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input logic clk,
  input logic rst,
  input logic [4:0] raddr1,
  input logic [4:0] raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input decode_pkg::wb_write_t wr
);

  logic [31:0] regs [0:31];

  // Entry 0 is cleared by reset and skipped by every write.
  always_ff @(posedge clk) begin
    if (!rst) begin
      regs[0] <= 32'd0;
    end else if (wr.wren && wr.waddr != 5'd0) begin
      regs[wr.waddr] <= wr.wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // Writebacks aimed at x0 must never disturb the stored zero.
  assert property (@(posedge clk) disable iff (!rst) regs[0] == 32'd0);

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input logic [31:0] instr,
  output decode_pkg::decoder_ctrl_t ctrl
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::alu_op_e alu_sel;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  // Compressed words never match a major opcode, so they fall out as illegal.
  assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'b000: alu_sel = (funct7 == rv_isa_pkg::funct7_alt) ? rv_isa_pkg::alu_sub
                                                           : rv_isa_pkg::alu_add;
      3'b001: alu_sel = rv_isa_pkg::alu_sll;
      3'b010: alu_sel = rv_isa_pkg::alu_slt;
      3'b011: alu_sel = rv_isa_pkg::alu_sltu;
      3'b100: alu_sel = rv_isa_pkg::alu_xor;
      3'b101: alu_sel = (funct7 == rv_isa_pkg::funct7_alt) ? rv_isa_pkg::alu_sra
                                                           : rv_isa_pkg::alu_srl;
      3'b110: alu_sel = rv_isa_pkg::alu_or;
      default: alu_sel = rv_isa_pkg::alu_and;
    endcase
  end

  always_comb begin
    ctrl = '0; // Default op fields are add, beq and lb.
    case (opcode)
      rv_isa_pkg::op_lui: begin
        ctrl.imm = imm_u;
        ctrl.wren = 1'b1;
        ctrl.lui = 1'b1;
        ctrl.valid = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        ctrl.imm = imm_u;
        ctrl.wren = 1'b1;
        ctrl.auipc = 1'b1;
        ctrl.valid = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        ctrl.imm = imm_j;
        ctrl.wren = 1'b1;
        ctrl.jal = 1'b1;
        ctrl.valid = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        ctrl.imm = imm_i;
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        ctrl.jalr = 1'b1;
        ctrl.valid = (funct3 == 3'b000);
      end
      rv_isa_pkg::op_branch: begin
        ctrl.imm = imm_b;
        ctrl.rden1 = 1'b1;
        ctrl.rden2 = 1'b1;
        ctrl.branch = 1'b1;
        ctrl.bcu_op = rv_isa_pkg::bcu_op_e'(funct3);
        ctrl.valid = (funct3[2:1] != 2'b01); // funct3 2 and 3 are reserved.
      end
      rv_isa_pkg::op_load: begin
        ctrl.imm = imm_i;
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        ctrl.load = 1'b1;
        ctrl.valid = 1'b1;
        case (funct3)
          3'b000: ctrl.lsu_op = rv_isa_pkg::lsu_lb;
          3'b001: ctrl.lsu_op = rv_isa_pkg::lsu_lh;
          3'b010: ctrl.lsu_op = rv_isa_pkg::lsu_lw;
          3'b100: ctrl.lsu_op = rv_isa_pkg::lsu_lbu;
          3'b101: ctrl.lsu_op = rv_isa_pkg::lsu_lhu;
          default: ctrl.valid = 1'b0;
        endcase
      end
      rv_isa_pkg::op_store: begin
        ctrl.imm = imm_s;
        ctrl.rden1 = 1'b1;
        ctrl.rden2 = 1'b1;
        ctrl.store = 1'b1;
        ctrl.valid = 1'b1;
        case (funct3)
          3'b000: ctrl.lsu_op = rv_isa_pkg::lsu_sb;
          3'b001: ctrl.lsu_op = rv_isa_pkg::lsu_sh;
          3'b010: ctrl.lsu_op = rv_isa_pkg::lsu_sw;
          default: ctrl.valid = 1'b0;
        endcase
      end
      rv_isa_pkg::op_imm: begin
        ctrl.imm = imm_i;
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        // Bit 30 belongs to the immediate of addi, so it never means sub here.
        ctrl.alu_op = (funct3 == 3'b000) ? rv_isa_pkg::alu_add : alu_sel;
        if (funct3 == 3'b001) begin
          ctrl.valid = (funct7 == rv_isa_pkg::funct7_base);
        end else if (funct3 == 3'b101) begin
          ctrl.valid = (funct7 == rv_isa_pkg::funct7_base) ||
                       (funct7 == rv_isa_pkg::funct7_alt);
        end else begin
          ctrl.valid = 1'b1;
        end
      end
      rv_isa_pkg::op_reg: begin
        ctrl.wren = 1'b1;
        ctrl.rden1 = 1'b1;
        ctrl.rden2 = 1'b1;
        ctrl.alu_op = alu_sel;
        ctrl.valid = (funct7 == rv_isa_pkg::funct7_base) ||
                     ((funct7 == rv_isa_pkg::funct7_alt) &&
                      (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_isa_pkg::op_system: begin
        ctrl.ecall = (instr == rv_isa_pkg::instr_ecall);
        ctrl.ebreak = (instr == rv_isa_pkg::instr_ebreak);
        ctrl.valid = ctrl.ecall || ctrl.ebreak; // CSR, mret and wfi are not supported.
      end
      default: ctrl.valid = 1'b0;
    endcase
    if (!ctrl.valid) begin
      ctrl = '0;
    end
  end

  // The stage steers the address unit from these, so two classes must never overlap.
  always_comb begin
    assert ($onehot0({ctrl.load, ctrl.store, ctrl.branch, ctrl.jal, ctrl.jalr}));
  end

endmodule

`default_nettype wire

// File: verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [rv_isa_pkg::xlen-1:0] instr;
    logic valid;
  } fetch_item_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] imm;
    logic wren, rden1, rden2;
    logic auipc, lui, jal, jalr;
    logic branch, load, store;
    logic ecall, ebreak;
    logic valid; // Set only for a legal encoding.
    rv_isa_pkg::alu_op_e alu_op;
    rv_isa_pkg::bcu_op_e bcu_op;
    rv_isa_pkg::lsu_op_e lsu_op;
  } decoder_ctrl_t;

  typedef struct packed {
    logic wren;
    logic [4:0] waddr;
    logic [rv_isa_pkg::xlen-1:0] wdata;
  } wb_write_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] rdata1;
    logic [rv_isa_pkg::xlen-1:0] imm;
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic jalr, load, store;
    rv_isa_pkg::lsu_op_e lsu_op;
  } agu_req_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] address;
    logic [3:0] byteenable;
    logic exception;
    rv_isa_pkg::ecause_e ecause;
  } agu_res_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [rv_isa_pkg::xlen-1:0] npc;
    logic [rv_isa_pkg::xlen-1:0] imm;
    logic [4:0] waddr, raddr1, raddr2;
    logic [rv_isa_pkg::xlen-1:0] rdata1;
    logic [rv_isa_pkg::xlen-1:0] rdata2;
    logic wren, rden1, rden2;
    logic auipc, lui, jal, jalr;
    logic branch, load, store;
    logic ecall, ebreak, valid;
    logic jump;
    logic [rv_isa_pkg::xlen-1:0] address;
    logic [3:0] byteenable;
    rv_isa_pkg::alu_op_e alu_op;
    rv_isa_pkg::bcu_op_e bcu_op;
    rv_isa_pkg::lsu_op_e lsu_op;
    logic exception;
    rv_isa_pkg::ecause_e ecause;
    logic [rv_isa_pkg::xlen-1:0] etval;
  } decode_item_t;

  typedef struct packed {
    logic mem_valid;
    logic [rv_isa_pkg::xlen-1:0] mem_addr;
    logic [rv_isa_pkg::xlen-1:0] mem_wdata;
    logic [3:0] mem_wstrb;
  } dmem_req_t;

endpackage

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;

  // Extra funct7 and full-word encodings used by the decoder.
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;
  localparam logic [31:0] instr_ecall = 32'h00000073;
  localparam logic [31:0] instr_ebreak = 32'h00100073;

  typedef enum logic [6:0] {
    op_lui = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal = 7'b1101111,
    op_jalr = 7'b1100111,
    op_branch = 7'b1100011,
    op_load = 7'b0000011,
    op_store = 7'b0100011,
    op_imm = 7'b0010011,
    op_reg = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  // Values follow funct3 so the decoder can cast directly.
  typedef enum logic [2:0] {
    bcu_beq = 3'b000,
    bcu_bne = 3'b001,
    bcu_blt = 3'b100,
    bcu_bge = 3'b101,
    bcu_bltu = 3'b110,
    bcu_bgeu = 3'b111
  } bcu_op_e;

  typedef enum logic [2:0] {
    lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw
  } lsu_op_e;

  typedef enum logic [3:0] {
    ecause_illegal = 4'd2,
    ecause_breakpoint = 4'd3,
    ecause_load_misaligned = 4'd4,
    ecause_store_misaligned = 4'd6,
    ecause_ecall_m = 4'd11
  } ecause_e;

endpackage

`default_nettype wire
